/* hdl/sound_params.svh */
`ifndef SOUND_PARAMS_SVH
`define SOUND_PARAMS_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////
`define FLASH_AW    23
`define SAMPLE_W    8
`define RAM_LOGSIZE 8  // 256 words, enough for sim clips

////////////////////////////////////////
// flash regions, inclusive bounds
////////////////////////////////////////
// music loops over 16 bytes in sim
`define MUSIC_START   23'h000100
`define MUSIC_END     23'h00010f
`define POP_START     23'h000200  // 4 bytes
`define POP_END       23'h000203
`define MISSED_START  23'h000300  // 5 bytes
`define MISSED_END    23'h000304
`define WHACKED_START 23'h000400  // 3 bytes
`define WHACKED_END   23'h000402

////////////////////////////////////////
// low-pass filter
////////////////////////////////////////
`define FIR_TAPS  31
`define COEFF_W   10
`define ACC_W     18
`define FIR_SHIFT 10  // coeffs scaled by 2**10

`endif

/* hdl/sound_pkg.sv */
`default_nettype none

package sound_pkg;

	// game FSM encoding, shared with the game logic
	typedef enum logic [3:0] {
		gs_idle           = 4'd0,   // waiting for start
		gs_ongoing        = 4'd2,
		gs_request_mole   = 4'd3,
		gs_mole_countdown = 4'd4,   // mole up, pop clip plays
		gs_mole_missed    = 4'd5,
		gs_mole_whacked   = 4'd6,
		gs_missed_sound   = 4'd9,   // extra time for missed clip
		gs_whacked_sound  = 4'd10   // extra time for whacked clip
	} game_state_e;

	// loader steps, in flash region order
	typedef enum logic [2:0] {
		ld_pop_start,
		ld_pop,
		ld_missed_start,
		ld_missed,
		ld_whacked_start,
		ld_whacked,
		ld_done
	} load_state_e;

endpackage

`default_nettype wire

/* hdl/sample_ram.sv */
`timescale 1ns/1ps
`default_nettype none

// effect clip storage, one port shared by loader and player
module sample_ram #(
	parameter int LOGSIZE = 8,
	parameter int WIDTH   = 8
) (
	input  wire               clock,
	input  wire               we,
	input  wire [LOGSIZE-1:0] addr,
	input  wire [WIDTH-1:0]   din,
	output logic [WIDTH-1:0]  dout
);

	logic [WIDTH-1:0] mem [0:(1 << LOGSIZE)-1];

	always_ff @(posedge clock) begin
		if (we)
			mem[addr] <= din;
		dout <= mem[addr];  // old word on a write cycle
	end

endmodule

`default_nettype wire

/* hdl/fir_lowpass.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sound_params.svh"

// serial 31-tap low-pass, one multiply per cycle after each ready
module fir_lowpass (
	input  wire                        clock,
	input  wire                        reset,
	input  wire                        ready,
	input  wire signed [`SAMPLE_W-1:0] x,
	output logic signed [`ACC_W-1:0]   y
);

	logic signed [`SAMPLE_W-1:0] sample [0:31];  // circular history
	logic [4:0] offset;                          // next slot to fill
	logic [4:0] index;                           // tap in progress
	logic [4:0] tap_slot;
	logic signed [`COEFF_W-1:0] coeff;
	logic signed [`ACC_W-1:0] sum;
	logic signed [`ACC_W-1:0] product;

	assign tap_slot = offset - 5'd1 - index;      // newest sample is at offset-1
	assign product  = coeff * sample[tap_slot];

	////////////////////////////////////////
	// coefficient ROM, Wn=.125, scaled by 2**10
	////////////////////////////////////////
	always_comb begin
		case (index)
			5'd0, 5'd1, 5'd29, 5'd30: coeff = -10'sd1;
			5'd2, 5'd28:              coeff = -10'sd3;
			5'd3, 5'd27:              coeff = -10'sd5;
			5'd4, 5'd26:              coeff = -10'sd6;
			5'd5, 5'd25:              coeff = -10'sd7;
			5'd6, 5'd24:              coeff = -10'sd5;
			5'd7, 5'd23:              coeff = 10'sd0;
			5'd8, 5'd22:              coeff = 10'sd10;
			5'd9, 5'd21:              coeff = 10'sd26;
			5'd10, 5'd20:             coeff = 10'sd46;
			5'd11, 5'd19:             coeff = 10'sd69;
			5'd12, 5'd18:             coeff = 10'sd91;
			5'd13, 5'd17:             coeff = 10'sd110;
			5'd14, 5'd16:             coeff = 10'sd123;
			5'd15:                    coeff = 10'sd128;  // center tap
			default:                  coeff = '0;        // idle index
		endcase
	end

	////////////////////////////////////////
	// sample store and accumulate
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			offset <= '0;
			index  <= 5'(`FIR_TAPS);  // parked, nothing to sum
			sum    <= '0;
			y      <= '0;
			for (int i = 0; i < 32; i++)
				sample[i] <= '0;        // history starts silent
		end else if (ready) begin
			sample[offset] <= x;
			offset <= offset + 5'd1;
			index  <= '0;
			sum    <= '0;
		end else if (index < 5'(`FIR_TAPS)) begin
			index <= index + 5'd1;
			sum   <= sum + product;
			if (index == 5'(`FIR_TAPS - 1))
				y <= sum + product;     // valid 32 cycles after ready
		end
	end

	// a new sample mid-sum would corrupt the result
	a_ready_spacing: assert property (@(posedge clock) disable iff (reset)
		ready |=> !ready [* `FIR_TAPS])
		else $error("fir ready arrived during accumulation");

endmodule

`default_nettype wire

/* hdl/effect_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sound_params.svh"

// copies pop, missed, whacked clips from flash into sample ram
module effect_loader import sound_pkg::*; (
	input  wire                       clock,
	input  wire                       reset,
	input  wire                       flash_busy,
	input  wire [`SAMPLE_W-1:0]       flash_data,
	output logic [`FLASH_AW-1:0]      ld_addr,
	output logic                      ld_read,
	output logic                      ram_we,
	output logic [`RAM_LOGSIZE-1:0]   ram_addr_wr,
	output logic [`SAMPLE_W-1:0]      ram_din,
	output logic [`RAM_LOGSIZE-1:0]   pop_start,
	output logic [`RAM_LOGSIZE-1:0]   pop_end,
	output logic [`RAM_LOGSIZE-1:0]   missed_start,
	output logic [`RAM_LOGSIZE-1:0]   missed_end,
	output logic [`RAM_LOGSIZE-1:0]   whacked_start,
	output logic [`RAM_LOGSIZE-1:0]   whacked_end,
	output logic                      loaded
);

	load_state_e state;
	logic waiting;                     // read accepted, data not back yet
	logic [`RAM_LOGSIZE:0] fill;       // next free ram word, one extra bit
	logic [`FLASH_AW-1:0] region_first;
	logic [`FLASH_AW-1:0] region_last;

	// flash bounds of the clip being copied
	always_comb begin
		case (state)
			ld_pop_start, ld_pop: begin
				region_first = `POP_START;
				region_last  = `POP_END;
			end
			ld_missed_start, ld_missed: begin
				region_first = `MISSED_START;
				region_last  = `MISSED_END;
			end
			default: begin
				region_first = `WHACKED_START;
				region_last  = `WHACKED_END;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state   <= ld_pop_start;
			waiting <= 1'b0;
			fill    <= '0;
			ld_addr <= '0;
			ld_read <= 1'b0;
			ram_we  <= 1'b0;
			loaded  <= 1'b0;
		end else begin
			ram_we <= 1'b0;  // single-cycle write pulse
			case (state)
				ld_pop_start, ld_missed_start, ld_whacked_start: begin
					case (state)
						ld_pop_start:    pop_start     <= fill[`RAM_LOGSIZE-1:0];
						ld_missed_start: missed_start  <= fill[`RAM_LOGSIZE-1:0];
						default:         whacked_start <= fill[`RAM_LOGSIZE-1:0];
					endcase
					ld_addr <= region_first;
					ld_read <= 1'b1;
					waiting <= 1'b0;
					state   <= load_state_e'(state + 3'd1);  // into its copy state
				end
				ld_pop, ld_missed, ld_whacked: begin
					if (ld_read && !flash_busy) begin
						ld_read <= 1'b0;  // accepted, busy rises next
						waiting <= 1'b1;
					end else if (waiting && !flash_busy) begin
						waiting     <= 1'b0;
						ram_we      <= 1'b1;
						ram_din     <= flash_data;
						ram_addr_wr <= fill[`RAM_LOGSIZE-1:0];
						fill        <= fill + 1'b1;
						case (state)
							ld_pop:    pop_end     <= fill[`RAM_LOGSIZE-1:0];
							ld_missed: missed_end  <= fill[`RAM_LOGSIZE-1:0];
							default:   whacked_end <= fill[`RAM_LOGSIZE-1:0];
						endcase
						if (ld_addr == region_last) begin
							state <= load_state_e'(state + 3'd1);  // next clip or done
						end else begin
							ld_addr <= ld_addr + 1'b1;
							ld_read <= 1'b1;
						end
					end
				end
				default: loaded <= 1'b1;  // one cycle after last write
			endcase
		end
	end

	// clips must fit in the sample ram
	a_ram_fits: assert property (@(posedge clock) disable iff (reset)
		ram_we |-> fill <= (1 << `RAM_LOGSIZE))
		else $error("effect clips overflow sample ram");

endmodule

`default_nettype wire

/* hdl/sound_player.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sound_params.svh"

// music stream plus effect clips, driven by game state
module sound_player import sound_pkg::*; (
	input  wire                        clock,
	input  wire                        reset,
	input  wire                        ready,
	input  wire game_state_e           game_state,
	input  wire                        loaded,
	input  wire [`FLASH_AW-1:0]        ld_addr,
	input  wire                        ld_read,
	input  wire                        flash_busy,
	input  wire [`SAMPLE_W-1:0]        flash_data,
	input  wire [`RAM_LOGSIZE-1:0]     pop_start,
	input  wire [`RAM_LOGSIZE-1:0]     pop_end,
	input  wire [`RAM_LOGSIZE-1:0]     missed_start,
	input  wire [`RAM_LOGSIZE-1:0]     missed_end,
	input  wire [`RAM_LOGSIZE-1:0]     whacked_start,
	input  wire [`RAM_LOGSIZE-1:0]     whacked_end,
	input  wire [`SAMPLE_W-1:0]        ram_dout,
	input  wire [`RAM_LOGSIZE-1:0]     ram_addr_wr,
	output logic [`RAM_LOGSIZE-1:0]    ram_addr,
	input  wire signed [`ACC_W-1:0]    fir_y,
	output logic signed [`SAMPLE_W-1:0] fir_x,
	output logic [`FLASH_AW-1:0]       flash_addr,
	output logic                       flash_read,
	output logic [`SAMPLE_W-1:0]       to_ac97_data
);

	game_state_e prev_state;           // for entry detection
	logic [`FLASH_AW-1:0] music_addr;
	logic music_read;                  // one read per sample
	logic [`RAM_LOGSIZE-1:0] clip_addr;
	logic [`RAM_LOGSIZE-1:0] clip_first;
	logic [`RAM_LOGSIZE-1:0] clip_last;
	logic clip_done;
	logic is_effect;
	logic entering;
	logic leaving_idle;
	logic stall;
	logic [`SAMPLE_W-1:0] music_byte;

	// loader owns flash and ram until loaded
	assign flash_addr = loaded ? music_addr : ld_addr;
	assign flash_read = loaded ? music_read : ld_read;
	assign ram_addr   = loaded ? clip_addr : ram_addr_wr;

	////////////////////////////////////////
	// clip select and sample gating
	////////////////////////////////////////
	always_comb begin
		is_effect  = 1'b1;
		clip_first = pop_start;
		clip_last  = pop_end;
		case (game_state)
			gs_mole_countdown: is_effect = 1'b1;  // pop clip
			gs_missed_sound: begin
				clip_first = missed_start;
				clip_last  = missed_end;
			end
			gs_whacked_sound: begin
				clip_first = whacked_start;
				clip_last  = whacked_end;
			end
			default: is_effect = 1'b0;  // music only
		endcase
	end

	assign entering     = loaded && is_effect && (game_state != prev_state);
	assign leaving_idle = loaded && (game_state != gs_idle) && (prev_state == gs_idle);
	assign stall        = flash_busy || music_read || leaving_idle;  // byte not ready yet
	assign music_byte   = fir_y[`FIR_SHIFT +: `SAMPLE_W];

	always_ff @(posedge clock) begin
		if (reset) begin
			prev_state   <= gs_idle;
			music_addr   <= `MUSIC_START;
			music_read   <= 1'b0;
			clip_addr    <= '0;
			clip_done    <= 1'b1;
			fir_x        <= '0;
			to_ac97_data <= '0;
		end else if (loaded) begin
			prev_state <= game_state;
			if (music_read && !flash_busy)
				music_read <= 1'b0;  // accepted by flash
			if (game_state == gs_idle) begin
				music_addr <= `MUSIC_START;  // rewind
				music_read <= 1'b0;
				fir_x      <= '0;
				if (ready)
					to_ac97_data <= '0;
			end else begin
				if (!flash_busy)
					fir_x <= flash_data;   // filter picks it up at ready
				if (leaving_idle)
					music_read <= 1'b1;    // fetch MUSIC_START
				if (entering) begin
					clip_addr <= clip_first;
					clip_done <= 1'b0;
				end
				if (ready && !stall) begin
					music_addr <= (music_addr >= `MUSIC_END) ? `MUSIC_START : music_addr + 1'b1;
					music_read <= 1'b1;
					if (is_effect && !clip_done && !entering) begin
						to_ac97_data <= music_byte + ram_dout;  // wraps mod 256
						if (clip_addr == clip_last)
							clip_done <= 1'b1;
						else
							clip_addr <= clip_addr + 1'b1;
					end else begin
						to_ac97_data <= music_byte;
					end
				end
			end
		end
	end

	// codec sees a new value only right after a ready
	a_out_on_ready: assert property (@(posedge clock) disable iff (reset)
		!$past(ready) |-> $stable(to_ac97_data))
		else $error("to_ac97_data changed without ready");

endmodule

`default_nettype wire

/* hdl/sound_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sound_params.svh"

// sound engine: loader, sample ram, filter, player
module sound_top import sound_pkg::*; (
	input  wire                  clock,
	input  wire                  reset,
	input  wire                  ready,       // audio strobe
	input  wire game_state_e     game_state,
	input  wire                  flash_busy,
	input  wire [`SAMPLE_W-1:0]  flash_data,
	output wire [`FLASH_AW-1:0]  flash_addr,
	output wire                  flash_read,
	output wire                  loaded,
	output wire [`SAMPLE_W-1:0]  to_ac97_data
);

	wire [`FLASH_AW-1:0] ld_addr;
	wire ld_read;
	wire ram_we;
	wire [`RAM_LOGSIZE-1:0] ram_addr_wr;
	wire [`RAM_LOGSIZE-1:0] ram_addr;    // muxed inside player
	wire [`SAMPLE_W-1:0] ram_din;
	wire [`SAMPLE_W-1:0] ram_dout;
	wire [`RAM_LOGSIZE-1:0] pop_start, pop_end;
	wire [`RAM_LOGSIZE-1:0] missed_start, missed_end;
	wire [`RAM_LOGSIZE-1:0] whacked_start, whacked_end;
	wire signed [`SAMPLE_W-1:0] fir_x;
	wire signed [`ACC_W-1:0] fir_y;

	effect_loader loader (
		.clock(clock), .reset(reset),
		.flash_busy(flash_busy), .flash_data(flash_data),
		.ld_addr(ld_addr), .ld_read(ld_read),
		.ram_we(ram_we), .ram_addr_wr(ram_addr_wr), .ram_din(ram_din),
		.pop_start(pop_start), .pop_end(pop_end),
		.missed_start(missed_start), .missed_end(missed_end),
		.whacked_start(whacked_start), .whacked_end(whacked_end),
		.loaded(loaded)
	);

	sample_ram #(.LOGSIZE(`RAM_LOGSIZE), .WIDTH(`SAMPLE_W)) clip_ram (
		.clock(clock), .we(ram_we), .addr(ram_addr), .din(ram_din), .dout(ram_dout)
	);

	fir_lowpass music_fir (
		.clock(clock), .reset(reset), .ready(ready), .x(fir_x), .y(fir_y)
	);

	sound_player player (
		.clock(clock), .reset(reset), .ready(ready),
		.game_state(game_state), .loaded(loaded),
		.ld_addr(ld_addr), .ld_read(ld_read),
		.flash_busy(flash_busy), .flash_data(flash_data),
		.pop_start(pop_start), .pop_end(pop_end),
		.missed_start(missed_start), .missed_end(missed_end),
		.whacked_start(whacked_start), .whacked_end(whacked_end),
		.ram_dout(ram_dout), .ram_addr_wr(ram_addr_wr), .ram_addr(ram_addr),
		.fir_y(fir_y), .fir_x(fir_x),
		.flash_addr(flash_addr), .flash_read(flash_read),
		.to_ac97_data(to_ac97_data)
	);

endmodule

`default_nettype wire

/* tb/tb_sound_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sound_params.svh"

module tb_sound_top import sound_pkg::*; ();

	logic clock;
	logic reset;
	logic ready;
	game_state_e game_state;
	logic flash_busy;
	logic [`SAMPLE_W-1:0] flash_data;
	wire [`FLASH_AW-1:0] flash_addr;
	wire flash_read;
	wire loaded;
	wire [`SAMPLE_W-1:0] to_ac97_data;

	logic [7:0] image [0:'h4ff];      // flash contents from golden file
	int read_log[$];                  // accepted flash addresses
	int busy_cnt;
	logic hold_busy;                  // forces back-pressure
	integer seed;
	int errors;

	sound_top uut (
		.clock(clock), .reset(reset), .ready(ready), .game_state(game_state),
		.flash_busy(flash_busy), .flash_data(flash_data),
		.flash_addr(flash_addr), .flash_read(flash_read),
		.loaded(loaded), .to_ac97_data(to_ac97_data)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;  // 8 ns
	end

	task automatic check_value(input string name, input int actual, input int expected);
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("STATUS: FAIL");
		$fatal(1, "%s", what);
	endtask

	task automatic wait_ready_edge();
		int n;
		n = 0;
		do begin
			@(posedge clock);
			n++;
		end while (!ready && n < 100);
		if (!ready)
			report_failure("timed out waiting for the ready strobe");
	endtask

	function automatic int next_music_addr(input int a);
		return (a == `MUSIC_END) ? `MUSIC_START : a + 1;  // inclusive region wraps
	endfunction

	////////////////////////////////////////
	// audio strobe, one cycle every 48
	////////////////////////////////////////
	initial begin
		ready = 1'b0;
		forever begin
			repeat (47) @(posedge clock);
			#1 ready = 1'b1;
			@(posedge clock);
			#1 ready = 1'b0;
		end
	end

	////////////////////////////////////////
	// flash model, 2..9 cycles busy per read
	////////////////////////////////////////
	initial begin
		logic accept;
		int addr;
		seed = 32'hf861;
		busy_cnt = 0;
		hold_busy = 1'b0;
		flash_busy = 1'b0;
		flash_data = '0;
		forever begin
			@(posedge clock);
			accept = flash_read && !flash_busy && !reset;  // pre-edge values
			addr = flash_addr;
			#1;
			if (accept) begin
				read_log.push_back(addr);
				flash_data = image[addr];
				busy_cnt = 2 + ($unsigned($random(seed)) % 8);
			end else if (busy_cnt > 0)
				busy_cnt--;
			flash_busy = (busy_cnt > 0) || hold_busy;
		end
	end

	initial begin
		int fd, rc, nreg, nseg, start, count, st, samples, stall, exp_byte, exp_addr, a;
		int last_out, prev_st;
		string line;
		errors = 0;
		reset = 1'b1;
		game_state = gs_idle;
		fd = $fopen("tb/sound_golden.txt", "r");
		if (fd == 0)
			report_failure("cannot open tb/sound_golden.txt");
		rc = $fgets(line, fd);  // two column comment lines
		rc = $fgets(line, fd);
		rc = $fscanf(fd, "%d", nreg);
		for (int r = 0; r < nreg; r++) begin
			rc = $fscanf(fd, "%h %d", start, count);
			for (int i = 0; i < count; i++)
				rc = $fscanf(fd, "%h", image[start + i]);
		end

		repeat (5) @(posedge clock);
		#1;
		check_value("flash_read", flash_read, 0);  // quiet during reset
		check_value("loaded", loaded, 0);
		check_value("to_ac97_data", to_ac97_data, 0);
		reset = 1'b0;

		// loader copies pop, missed, whacked in order
		a = 0;
		while (!loaded && a < 2000) begin
			@(posedge clock);
			a++;
		end
		if (!loaded)
			report_failure("timed out waiting for loaded to rise");
		#1;
		check_value("load read count", read_log.size(), 12);
		for (int i = `POP_START; i <= `POP_END; i++)
			check_value("flash_addr", read_log.pop_front(), i);
		for (int i = `MISSED_START; i <= `MISSED_END; i++)
			check_value("flash_addr", read_log.pop_front(), i);
		for (int i = `WHACKED_START; i <= `WHACKED_END; i++)
			check_value("flash_addr", read_log.pop_front(), i);

		////////////////////////////////////////
		// game state script
		////////////////////////////////////////
		exp_addr = `MUSIC_START;
		last_out = 0;
		prev_st = 0;
		rc = $fscanf(fd, "%d", nseg);
		for (int s = 0; s < nseg; s++) begin
			rc = $fscanf(fd, "%d %d %d", st, samples, stall);
			game_state = game_state_e'(st);
			if (st != 0 && prev_st == 0)
				exp_addr = `MUSIC_START;  // rewound in idle
			prev_st = st;
			if (stall != 0) begin
				repeat (30) @(posedge clock);  // music read long finished
				#1;
				while (read_log.size() > 0) begin
					check_value("flash_addr", read_log.pop_front(), exp_addr);
					exp_addr = next_music_addr(exp_addr);
				end
				hold_busy = 1'b1;
				wait_ready_edge();
				#1;
				check_value("to_ac97_data", to_ac97_data, last_out);
				check_value("reads during stall", read_log.size(), 0);
				hold_busy = 1'b0;
			end
			for (int k = 0; k < samples; k++) begin
				rc = $fscanf(fd, "%h", exp_byte);
				wait_ready_edge();
				#1;
				check_value("to_ac97_data", to_ac97_data, exp_byte);
				while (read_log.size() > 0) begin
					check_value("flash_addr", read_log.pop_front(), exp_addr);
					exp_addr = next_music_addr(exp_addr);
				end
				last_out = exp_byte;
			end
		end
		$fclose(fd);

		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/sound_golden.txt */
# regions: start_addr(hex) byte_count bytes(hex); music first, then pop, missed, whacked
# segments: game_state samples stall_first_ready expected_audio_bytes(hex)
4
100 16 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
200 4 11 22 33 44
300 5 05 06 07 08 09
400 3 f0 f1 f2
9
0 3 0 00 00 00
2 20 0 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
4 6 0 11 22 33 44 00 00
9 7 0 05 06 07 08 09 00 00
10 5 0 f0 f1 f2 00 00
2 4 1 00 00 00 00
4 5 0 11 22 33 44 00
0 2 0 00 00
2 3 0 00 00 00

/* sources.f */
+incdir+hdl
hdl/sound_pkg.sv
hdl/sample_ram.sv
hdl/fir_lowpass.sv
hdl/effect_loader.sv
hdl/sound_player.sv
hdl/sound_top.sv
tb/tb_sound_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench, then judge the log
verilator --binary --timing -Wno-fatal --top-module tb_sound_top -f sources.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log || exit 1
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0
